// ==== rtl/tpu_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Sizing constants for the commit tracker, included by the package
// and by any module that needs a default depth or unit latency
//////////////////////////////////////////////////////////////////////
`ifndef TPU_CONSTS_SVH
`define TPU_CONSTS_SVH

// Issue number width, wraps modulo 64
`define TPU_ISSUE_WIDTH 6

// Reorder buffer depth
`define TPU_ROB_ENTRIES 16

// Unit latencies in cycles
`define TPU_LAT_LDST 4   // Both load/store units
`define TPU_LAT_MATH 3   // Math unit
`define TPU_LAT_MV   1   // Register move

`endif

// ==== rtl/tpuPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the commit tracker, referenced by scoped name
//////////////////////////////////////////////////////////////////////
`include "tpu_consts.svh"

package tpuPkg;

	////////////////////////////////////////////////////////////////////
	// Issue numbering
	////////////////////////////////////////////////////////////////////

	// Wraps modulo 2**TPU_ISSUE_WIDTH
	typedef logic [`TPU_ISSUE_WIDTH-1:0] issueNo;

	////////////////////////////////////////////////////////////////////
	// Unit select
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		unitLdSt1 = 2'd0,   // Load/store unit 1
		unitLdSt2 = 2'd1,   // Load/store unit 2
		unitMath  = 2'd2,   // Math unit
		unitMv    = 2'd3    // Register move
	} unitSel;

	////////////////////////////////////////////////////////////////////
	// Reorder buffer entry, 9 bits
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic   valid;   // Slot holds an instruction
		logic   done;    // Unit reported completion
		logic   slice;   // Must run alone
		issueNo issue;   // Issue number of the slot
	} commitEntry;

endpackage

// ==== rtl/ringBuffCtrl.sv ====
//////////////////////////////////////////////////////////////////////
// Pointer and occupancy control for a ring buffer of NUM_ENTRY slots
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ringBuffCtrl #(
	parameter int NUM_ENTRY = 16
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         we,      // Write one slot
	input  logic                         re,      // Release one slot
	output logic [$clog2(NUM_ENTRY)-1:0] wAddr,   // Next slot to write
	output logic [$clog2(NUM_ENTRY)-1:0] rAddr,   // Oldest slot
	output logic                         full,
	output logic                         empty,
	output logic [$clog2(NUM_ENTRY):0]   count    // Occupied slots
);

	localparam int ADDR_W = $clog2(NUM_ENTRY);

	logic doWrite;
	logic doRead;

	// Advance with wrap, depth need not be a power of two
	function automatic logic [ADDR_W-1:0] nextPtr(input logic [ADDR_W-1:0] ptr);
		if (ptr == ADDR_W'(NUM_ENTRY - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Ignore requests that would overrun or underrun
	assign doWrite = we & ~full;
	assign doRead  = re & ~empty;

	// Flags come from the counter only
	assign full  = (count == ($clog2(NUM_ENTRY) + 1)'(NUM_ENTRY));
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
			rAddr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wAddr <= nextPtr(wAddr);
			if (doRead)
				rAddr <= nextPtr(rAddr);
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

endmodule

// ==== rtl/reorderBuff.sv ====
//////////////////////////////////////////////////////////////////////
// Reorder buffer: marks completions by issue number and retires the
// head in issue order through a valid/ready commit port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tpu_consts.svh"

module reorderBuff #(
	parameter int NUM_ENTRY = `TPU_ROB_ENTRIES
) (
	input  logic           clock,
	input  logic           reset,
	// Store from issue
	input  logic           store,
	input  tpuPkg::issueNo storeNo,
	input  logic           storeSlice,
	// Completions from the four units
	input  logic           doneValidLdSt1,
	input  tpuPkg::issueNo doneNoLdSt1,
	input  logic           doneValidLdSt2,
	input  tpuPkg::issueNo doneNoLdSt2,
	input  logic           doneValidMath,
	input  tpuPkg::issueNo doneNoMath,
	input  logic           doneValidMv,
	input  tpuPkg::issueNo doneNoMv,
	// Commit to hazard side
	output logic           commitValid,
	output tpuPkg::issueNo commitNo,
	input  logic           commitReady,
	// Back-pressure to issue
	output logic           full,
	output logic           stall
);

	localparam int ADDR_W = $clog2(NUM_ENTRY);
	localparam int CNT_W  = ADDR_W + 1;

	tpuPkg::commitEntry entryTab [NUM_ENTRY];
	tpuPkg::commitEntry head;

	logic [NUM_ENTRY-1:0] setDone;     // Completion hits per slot
	logic [NUM_ENTRY-1:0] sliceWait;   // Slice slots behind the head

	logic              we;
	logic              re;
	logic              empty;
	logic [ADDR_W-1:0] wAddr;
	logic [ADDR_W-1:0] rAddr;
	logic [CNT_W-1:0]  count;

	// True when any active completion carries this number
	function automatic logic anyDone(input tpuPkg::issueNo num);
		logic hit;
		hit = (doneValidLdSt1 & (doneNoLdSt1 == num))
			| (doneValidLdSt2 & (doneNoLdSt2 == num))
			| (doneValidMath  & (doneNoMath  == num))
			| (doneValidMv    & (doneNoMv    == num));
		return hit;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Head and handshakes
	////////////////////////////////////////////////////////////////////

	assign head        = entryTab[rAddr];
	assign commitValid = ~empty & head.valid & head.done;
	assign commitNo    = head.issue;

	assign re   = commitValid & commitReady;   // Retire on handshake
	assign we   = store & ~full;
	assign full = (count == CNT_W'(NUM_ENTRY));

	// Slice must run alone, hold issue until it reaches the head
	assign stall = |sliceWait;

	always_comb begin
		for (int i = 0; i < NUM_ENTRY; i++) begin
			setDone[i]   = entryTab[i].valid & anyDone(entryTab[i].issue);
			sliceWait[i] = entryTab[i].valid & entryTab[i].slice
				& (ADDR_W'(i) != rAddr);
		end
	end

	////////////////////////////////////////////////////////////////////
	// Entry table
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ENTRY; i++) begin
				entryTab[i].valid <= 1'b0;
				entryTab[i].done  <= 1'b0;
				entryTab[i].slice <= 1'b0;
			end
		end else begin
			for (int i = 0; i < NUM_ENTRY; i++) begin
				if (setDone[i])
					entryTab[i].done <= 1'b1;
			end
			if (re) begin   // Free the head slot
				entryTab[rAddr].valid <= 1'b0;
				entryTab[rAddr].done  <= 1'b0;
				entryTab[rAddr].slice <= 1'b0;
			end
			// Never the head slot here, a full buffer blocks the store
			if (we) begin
				entryTab[wAddr].valid <= 1'b1;
				entryTab[wAddr].done  <= 1'b0;
				entryTab[wAddr].slice <= storeSlice;
				entryTab[wAddr].issue <= storeNo;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Ring pointers
	////////////////////////////////////////////////////////////////////

	ringBuffCtrl #(
		.NUM_ENTRY (NUM_ENTRY)
	) ringCtrl_i (
		.clock (clock),
		.reset (reset),
		.we    (we),
		.re    (re),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (),        // Full taken from count above
		.empty (empty),
		.count (count)
	);

endmodule

// ==== rtl/issueUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Issue stage: numbers accepted instructions, stores them in the
// reorder buffer and starts the selected unit in the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module issueUnit (
	input  logic           clock,
	input  logic           reset,
	// Instruction input
	input  logic           inValid,
	output logic           inReady,
	input  tpuPkg::unitSel inUnit,
	input  logic           inSlice,
	// Buffer state
	input  logic           full,
	input  logic           stall,
	// Store port
	output logic           robStore,
	output tpuPkg::issueNo robIssueNo,
	output logic           robSlice,
	// One-hot unit starts
	output logic           startLdSt1,
	output logic           startLdSt2,
	output logic           startMath,
	output logic           startMv
);

	tpuPkg::issueNo nextNo;   // Number for the next transfer
	logic           xfer;

	////////////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////////////

	assign inReady = ~full & ~stall;
	assign xfer    = inValid & inReady;

	// Counter wraps with the type width
	always_ff @(posedge clock) begin
		if (reset)
			nextNo <= '0;
		else if (xfer)
			nextNo <= nextNo + 1'b1;
	end

	////////////////////////////////////////////////////////////////////
	// Store and dispatch, no register
	////////////////////////////////////////////////////////////////////

	assign robStore   = xfer;
	assign robIssueNo = nextNo;   // Also fans out to every unit
	assign robSlice   = inSlice;

	always_comb begin
		startLdSt1 = 1'b0;
		startLdSt2 = 1'b0;
		startMath  = 1'b0;
		startMv    = 1'b0;
		if (xfer) begin
			case (inUnit)
				tpuPkg::unitLdSt1: startLdSt1 = 1'b1;
				tpuPkg::unitLdSt2: startLdSt2 = 1'b1;
				tpuPkg::unitMath:  startMath  = 1'b1;
				default:           startMv    = 1'b1;
			endcase
		end
	end

endmodule

// ==== rtl/execUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Fixed-latency unit model, carries issue numbers to completion
// LATENCY cycles after start, one new start per cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execUnit #(
	parameter int LATENCY = 1   // At least 1
) (
	input  logic           clock,
	input  logic           reset,
	input  logic           startValid,
	input  tpuPkg::issueNo startNo,
	output logic           doneValid,
	output tpuPkg::issueNo doneNo
);

	logic [LATENCY-1:0] stageValid;
	tpuPkg::issueNo     stageNo [LATENCY];

	// Valid chain, cleared on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= '0;
		end else begin
			stageValid[0] <= startValid;
			for (int i = 1; i < LATENCY; i++)
				stageValid[i] <= stageValid[i-1];
		end
	end

	// Number chain follows the valids
	always_ff @(posedge clock) begin
		stageNo[0] <= startNo;
		for (int i = 1; i < LATENCY; i++)
			stageNo[i] <= stageNo[i-1];
	end

	assign doneValid = stageValid[LATENCY-1];
	assign doneNo    = stageNo[LATENCY-1];

endmodule

// ==== rtl/commitEngine.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the commit tracker: issue, four execution units and
// the reorder buffer, instruction in and in-order commit out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tpu_consts.svh"

module commitEngine (
	input  logic           clock,
	input  logic           reset,
	input  logic           inValid,
	output logic           inReady,
	input  tpuPkg::unitSel inUnit,
	input  logic           inSlice,
	output logic           commitValid,
	output tpuPkg::issueNo commitNo,
	input  logic           commitReady
);

	logic           robFull;
	logic           robStall;
	logic           robStore;
	logic           robSlice;
	tpuPkg::issueNo robIssueNo;   // Shared by all unit starts

	logic startLdSt1, startLdSt2, startMath, startMv;

	logic           doneValidLdSt1, doneValidLdSt2, doneValidMath, doneValidMv;
	tpuPkg::issueNo doneNoLdSt1, doneNoLdSt2, doneNoMath, doneNoMv;

	////////////////////////////////////////////////////////////////////
	// Issue
	////////////////////////////////////////////////////////////////////

	issueUnit issueUnit_i (
		.clock      (clock),
		.reset      (reset),
		.inValid    (inValid),
		.inReady    (inReady),
		.inUnit     (inUnit),
		.inSlice    (inSlice),
		.full       (robFull),
		.stall      (robStall),
		.robStore   (robStore),
		.robIssueNo (robIssueNo),
		.robSlice   (robSlice),
		.startLdSt1 (startLdSt1),
		.startLdSt2 (startLdSt2),
		.startMath  (startMath),
		.startMv    (startMv)
	);

	////////////////////////////////////////////////////////////////////
	// Execution units
	////////////////////////////////////////////////////////////////////

	execUnit #(.LATENCY(`TPU_LAT_LDST)) execLdSt1_i (
		.clock (clock), .reset (reset),
		.startValid (startLdSt1), .startNo (robIssueNo),
		.doneValid (doneValidLdSt1), .doneNo (doneNoLdSt1)
	);

	execUnit #(.LATENCY(`TPU_LAT_LDST)) execLdSt2_i (
		.clock (clock), .reset (reset),
		.startValid (startLdSt2), .startNo (robIssueNo),
		.doneValid (doneValidLdSt2), .doneNo (doneNoLdSt2)
	);

	execUnit #(.LATENCY(`TPU_LAT_MATH)) execMath_i (
		.clock (clock), .reset (reset),
		.startValid (startMath), .startNo (robIssueNo),
		.doneValid (doneValidMath), .doneNo (doneNoMath)
	);

	execUnit #(.LATENCY(`TPU_LAT_MV)) execMv_i (
		.clock (clock), .reset (reset),
		.startValid (startMv), .startNo (robIssueNo),
		.doneValid (doneValidMv), .doneNo (doneNoMv)
	);

	////////////////////////////////////////////////////////////////////
	// Reorder buffer
	////////////////////////////////////////////////////////////////////

	reorderBuff #(.NUM_ENTRY(`TPU_ROB_ENTRIES)) reorderBuff_i (
		.clock          (clock),
		.reset          (reset),
		.store          (robStore),
		.storeNo        (robIssueNo),
		.storeSlice     (robSlice),
		.doneValidLdSt1 (doneValidLdSt1),
		.doneNoLdSt1    (doneNoLdSt1),
		.doneValidLdSt2 (doneValidLdSt2),
		.doneNoLdSt2    (doneNoLdSt2),
		.doneValidMath  (doneValidMath),
		.doneNoMath     (doneNoMath),
		.doneValidMv    (doneValidMv),
		.doneNoMv       (doneNoMv),
		.commitValid    (commitValid),
		.commitNo       (commitNo),
		.commitReady    (commitReady),
		.full           (robFull),
		.stall          (robStall)
	);

endmodule

// ==== tb/commitEngineTb.sv ====
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the commit tracker that checks in-order
// commit, numbering, full and slice back-pressure and a random mix
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tpu_consts.svh"

module commitEngineTb;

	localparam int TIMEOUT  = 500;   // Cycles allowed per wait
	localparam int NUM_ROWS = 8;
	localparam int NUM_RAND = 80;

	logic           clock = 1'b0;
	logic           reset;
	logic           inValid;
	logic           inReady;
	tpuPkg::unitSel inUnit;
	logic           inSlice;
	logic           commitValid;
	tpuPkg::issueNo commitNo;
	logic           commitReady;

	tpuPkg::issueNo refNo;               // Number of the next transfer
	tpuPkg::issueNo expQ [$];            // Accepted numbers in issue order
	int             commitIdx = 0;       // Next expected entry of expQ
	string          curName   = "reset";
	logic           blockCommit = 1'b0;  // Hold commitReady low
	int             holdUntil   = 0;     // Hold-off end in cycles
	int             cycleCount  = 0;
	integer         seed;
	int             randVal;
	int             waits;
	int             sliceIdx;

	// Stimulus table with inReady expected low after a slice row
	tpuPkg::unitSel rowUnit  [NUM_ROWS];
	logic           rowSlice [NUM_ROWS];
	int             rowHold  [NUM_ROWS];
	logic           rowStall [NUM_ROWS];
	string          rowName  [NUM_ROWS];

	commitEngine dut_i (
		.clock       (clock),
		.reset       (reset),
		.inValid     (inValid),
		.inReady     (inReady),
		.inUnit      (inUnit),
		.inSlice     (inSlice),
		.commitValid (commitValid),
		.commitNo    (commitNo),
		.commitReady (commitReady)
	);

	always #2 clock = ~clock;   // 4 ns period

	////////////////////////////////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////////////////////////////////

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic timeoutFail(input string what);
		$display("Timeout in %s: %s within %0d cycles", curName, what, TIMEOUT);
		abortRun();
	endtask

	task automatic checkNo(input string name, input tpuPkg::issueNo expVal,
			input tpuPkg::issueNo actVal);
		if (actVal !== expVal) begin
			$display("FAIL %s: expected %0d, actual %0d", name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			$display("FAIL %s: expected %b, actual %b", name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic setRow(input int idx, input tpuPkg::unitSel unit, input logic slice,
			input int hold, input logic stallExp, input string name);
		rowUnit[idx]  = unit;
		rowSlice[idx] = slice;
		rowHold[idx]  = hold;
		rowStall[idx] = stallExp;
		rowName[idx]  = name;
	endtask

	// Step to the drive point after the next rising edge
	task automatic alignDrive();
		@(posedge clock);
		#1;
	endtask

	// One transfer entered and left at the drive point
	task automatic sendInstr(input tpuPkg::unitSel unit, input logic slice, input int hold,
			output int waited);
		waited  = 0;
		inValid = 1'b1;
		inUnit  = unit;
		inSlice = slice;
		@(negedge clock);
		if (hold > 0)
			holdUntil = cycleCount + hold;   // Commit hold-off starts now
		while (!inReady) begin
			if (waited >= TIMEOUT)
				timeoutFail("inReady stayed low");
			waited++;
			@(negedge clock);
		end
		expQ.push_back(refNo);   // Transfer on the coming edge
		refNo = refNo + 1'b1;    // Wraps modulo 64
		alignDrive();
		inValid = 1'b0;
		inSlice = 1'b0;
	endtask

	task automatic waitReady();   // Called at a falling edge
		int cnt;
		cnt = 0;
		while (!inReady) begin
			if (cnt >= TIMEOUT)
				timeoutFail("inReady never rose");
			cnt++;
			@(negedge clock);
		end
	endtask

	task automatic waitDrain();
		int cnt;
		cnt = 0;
		while (commitIdx < expQ.size()) begin
			if (cnt >= TIMEOUT)
				timeoutFail("pending instructions never committed");
			cnt++;
			alignDrive();
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Commit ready driver and in-order checker
	////////////////////////////////////////////////////////////////////

	initial begin
		commitReady = 1'b0;
		forever begin
			alignDrive();
			commitReady = !(blockCommit || (cycleCount < holdUntil));
			cycleCount++;
		end
	end

	always @(negedge clock) begin
		if (!reset && commitValid && commitReady) begin
			if (commitIdx >= expQ.size()) begin
				$display("Commit of number %0d with nothing pending in %s", commitNo, curName);
				abortRun();
			end else begin
				checkNo({curName, " commit"}, expQ[commitIdx], commitNo);
			end
			commitIdx++;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	initial begin
		seed    = 32'h17c1_3e80;
		reset   = 1'b1;
		inValid = 1'b0;
		inUnit  = tpuPkg::unitLdSt1;
		inSlice = 1'b0;
		refNo   = '0;
		setRow(0, tpuPkg::unitLdSt1, 1'b0, 0, 1'b0, "order ldst first");
		setRow(1, tpuPkg::unitMv,    1'b0, 0, 1'b0, "order mv overtakes");
		setRow(2, tpuPkg::unitMath,  1'b0, 0, 1'b0, "slice older math");
		setRow(3, tpuPkg::unitMv,    1'b1, 0, 1'b1, "slice behind math");
		setRow(4, tpuPkg::unitLdSt2, 1'b0, 3, 1'b0, "holdoff ldst2");
		setRow(5, tpuPkg::unitMath,  1'b0, 0, 1'b0, "holdoff math");
		setRow(6, tpuPkg::unitLdSt1, 1'b1, 2, 1'b1, "slice behind ldst");
		setRow(7, tpuPkg::unitMv,    1'b0, 0, 1'b0, "after slice mv");
		repeat (5) @(posedge clock);   // Reset for 5 cycles
		#1;
		reset = 1'b0;

		@(negedge clock);
		checkBit("reset commitValid", 1'b0, commitValid);
		checkBit("reset inReady", 1'b1, inReady);
		alignDrive();

		// Slice rows must stall until older work commits
		for (int r = 0; r < NUM_ROWS; r++) begin
			curName = rowName[r];
			sendInstr(rowUnit[r], rowSlice[r], rowHold[r], waits);
			sliceIdx = expQ.size() - 1;
			@(negedge clock);
			checkBit({curName, " inReady"}, ~rowStall[r], inReady);
			if (rowStall[r]) begin
				waitReady();
				checkBit({curName, " older committed"}, 1'b1, commitIdx >= sliceIdx);
			end
			alignDrive();
		end
		waitDrain();

		////////////////////////////////////////////////////////////////
		// Full buffer with commit blocked
		////////////////////////////////////////////////////////////////
		curName = "full backpressure";
		@(negedge clock);
		blockCommit = 1'b1;
		alignDrive();
		for (int i = 0; i < `TPU_ROB_ENTRIES; i++) begin
			sendInstr(tpuPkg::unitSel'(2'(i)), 1'b0, 0, waits);
			checkBit("full accept without wait", 1'b1, waits == 0);
		end
		repeat (4) begin
			@(negedge clock);
			checkBit("full inReady", 1'b0, inReady);
		end
		blockCommit = 1'b0;   // Drain all 16 in order
		alignDrive();
		waitDrain();

		// Random units, slices and commit gaps
		curName = "random mix";
		for (int n = 0; n < NUM_RAND; n++) begin
			randVal = $random(seed);
			sendInstr(tpuPkg::unitSel'(randVal[1:0]), randVal[7:5] == 3'd0,
				randVal[13] ? int'(randVal[12:11]) : 0, waits);
		end
		waitDrain();

		curName = "idle";
		repeat (5) begin
			@(negedge clock);
			checkBit("idle commitValid", 1'b0, commitValid);
		end
		alignDrive();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/tpuPkg.sv
rtl/ringBuffCtrl.sv
rtl/reorderBuff.sv
rtl/issueUnit.sv
rtl/execUnit.sv
rtl/commitEngine.sv
tb/commitEngineTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the commit tracker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module commitEngineTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VcommitEngineTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
